// File: source/ce_params_pkg.sv
package ce_params_pkg;

	// pixels and weights enter the compute element as signed words

	// width of one signed pixel, upper or lower lane
	localparam int pixel_width = 16;

	// width of one signed kernel weight
	localparam int weight_width = 16;

	// accumulator width, matching the P port of a DSP slice
	// the P registers, the cascade buses and dataout_p all use it
	localparam int acc_width = 48;

	// a full product fits well inside the accumulator, so many beats
	// can be summed before the sum grows past acc_width

	// pooling results are sign-extended from pixel_width to acc_width
	// before they leave on dataout_p

endpackage

// File: source/ce_ctrl_pkg.sv
package ce_ctrl_pkg;

	// layer mode, loaded together with the window size on new_map
	localparam int mode_width = 2;

	localparam logic [mode_width-1:0] mode_conv     = 2'd0;
	localparam logic [mode_width-1:0] mode_max_pool = 2'd1;
	localparam logic [mode_width-1:0] mode_min_pool = 2'd2;

	// cycles from the beat that closes a window to its output valid
	// the convolution chain ends in the stage 4 register of the second slice
	localparam int pipe_latency = 4;

	// window size loaded by reset, so a window of four beats
	localparam int reset_window_size = 3;

	// code 3 is not used and behaves like a pooling mode

endpackage

// File: source/ce_beat_if.sv
`timescale 1ns/100ps

// tags for the current input cycle, all combinational in the cycle they
// describe, from the window controller to both slices and the pool unit
interface ce_beat_if;

	// this cycle carries data for the active mode
	logic beat;

	// opens a window
	logic first;

	// closes a window
	logic last;

	// cascade_datain is added into this window
	logic cascade_take;

	modport ctrl
	(
		output beat, first, last, cascade_take
	);

	modport dp
	(
		input beat, first, last, cascade_take
	);

endinterface

// File: source/ce_config_regs.sv
`timescale 1ns/100ps

module ce_config_regs
#(
	parameter int window_size_width = 4
)
(
	input  logic                               clk_5x,
	input  logic                               rst,
	input  logic                               new_map,
	input  logic [ce_ctrl_pkg::mode_width-1:0] mode_in,
	input  logic [window_size_width-1:0]       window_size_in,
	output logic [ce_ctrl_pkg::mode_width-1:0] mode,
	output logic [window_size_width-1:0]       window_size
);
	import ce_ctrl_pkg::*;

	// the layer setting holds for a whole feature map
	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			mode        <= mode_conv;
			window_size <= window_size_width'(reset_window_size);
		end
		else if (new_map)
		begin
			mode        <= mode_in;
			window_size <= window_size_in;
		end
	end

endmodule

// File: source/ce_window_ctrl.sv
`timescale 1ns/100ps

module ce_window_ctrl
#(
	parameter int window_size_width = 4
)
(
	input  logic                               clk_5x,
	input  logic                               rst,
	input  logic                               new_map,
	input  logic [ce_ctrl_pkg::mode_width-1:0] mode,
	input  logic [window_size_width-1:0]       window_size,
	input  logic                               pixel_valid_upper,
	input  logic                               pixel_valid_lower,
	input  logic                               weight_valid_upper,
	input  logic                               cascade_datain_valid,
	ce_beat_if.ctrl                            beat
);
	import ce_ctrl_pkg::*;

	logic [window_size_width-1:0] beat_count;
	logic                         is_beat;
	logic                         is_first;
	logic                         is_last;

	// convolution needs a pixel with its weight, pooling needs both pixels
	always_comb
	begin
		if (mode == mode_conv)
			is_beat = pixel_valid_upper & weight_valid_upper;
		else
			is_beat = pixel_valid_upper & pixel_valid_lower;
	end

	assign is_first = is_beat && (beat_count == '0);
	assign is_last  = is_beat && (beat_count == window_size);

	assign beat.beat         = is_beat;
	assign beat.first        = is_first;
	assign beat.last         = is_last;
	assign beat.cascade_take = is_first & cascade_datain_valid;

	// idle cycles leave the count alone, so gaps do not split a window
	always_ff @(posedge clk_5x)
	begin
		if (rst || new_map)
			beat_count <= '0;
		else if (is_beat)
		begin
			if (is_last)
				beat_count <= '0;
			else
				beat_count <= beat_count + 1'b1;
		end
	end

endmodule

// File: source/ce_macc_slice.sv
`timescale 1ns/100ps

module ce_macc_slice
#(
	parameter bit use_feedback = 1'b0
)
(
	input  logic                                      clk_5x,
	input  logic                                      rst,
	input  logic signed [ce_params_pkg::pixel_width-1:0]  pixel,
	input  logic signed [ce_params_pkg::weight_width-1:0] weight,
	input  logic signed [ce_params_pkg::acc_width-1:0]    pcin,
	ce_beat_if.dp                                     beat,
	output logic signed [ce_params_pkg::acc_width-1:0]    p,
	output logic                                      last
);
	import ce_params_pkg::*;
	import ce_ctrl_pkg::*;

	// the accumulating slice closes the chain, one stage behind the other
	localparam int p_stage   = use_feedback ? pipe_latency : pipe_latency - 1;
	localparam int in_stages = p_stage - 2;

	logic signed [pixel_width-1:0]              a_pipe [in_stages];
	logic signed [weight_width-1:0]             b_pipe [in_stages];
	logic signed [pixel_width+weight_width-1:0] m_reg;
	logic [in_stages:0]                         beat_pipe;
	logic [in_stages:0]                         first_pipe;
	logic [in_stages:0]                         last_pipe;

	// tags follow the data so that several windows can overlap
	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			beat_pipe  <= '0;
			first_pipe <= '0;
			last_pipe  <= '0;
			last       <= 1'b0;
		end
		else
		begin
			beat_pipe  <= {beat_pipe[in_stages-1:0], beat.beat};
			first_pipe <= {first_pipe[in_stages-1:0], beat.first};
			last_pipe  <= {last_pipe[in_stages-1:0], beat.last};
			last       <= last_pipe[in_stages];
		end
	end

	always_ff @(posedge clk_5x)
	begin
		a_pipe[0] <= pixel;
		b_pipe[0] <= weight;
		for (int i = 1; i < in_stages; i++)
		begin
			a_pipe[i] <= a_pipe[i-1];
			b_pipe[i] <= b_pipe[i-1];
		end
		m_reg <= a_pipe[in_stages-1] * b_pipe[in_stages-1];
		// a first beat drops the old P, like an opmode without the P term
		if (beat_pipe[in_stages])
		begin
			if (use_feedback && !first_pipe[in_stages])
				p <= p + acc_width'(m_reg) + pcin;
			else
				p <= acc_width'(m_reg) + pcin;
		end
	end

endmodule

// File: source/ce_pool_unit.sv
`timescale 1ns/100ps

module ce_pool_unit
(
	input  logic                                         clk_5x,
	input  logic                                         rst,
	input  logic [ce_ctrl_pkg::mode_width-1:0]           mode,
	input  logic signed [ce_params_pkg::pixel_width-1:0] pixel_upper,
	input  logic signed [ce_params_pkg::pixel_width-1:0] pixel_lower,
	ce_beat_if.dp                                        beat,
	output logic signed [ce_params_pkg::acc_width-1:0]   result,
	output logic                                         last
);
	import ce_params_pkg::*;
	import ce_ctrl_pkg::*;

	logic signed [pixel_width-1:0] up_reg;
	logic signed [pixel_width-1:0] low_reg;
	logic signed [pixel_width-1:0] pair_reg;
	logic signed [pixel_width-1:0] run_reg;
	logic [1:0]                    beat_pipe;
	logic [1:0]                    first_pipe;
	logic [pipe_latency-1:0]       last_pipe;
	logic                          want_max;

	// a DSP subtracts the two words and the sign bit picks the winner
	function automatic logic signed [pixel_width-1:0] pick
	(
		input logic signed [pixel_width-1:0] a,
		input logic signed [pixel_width-1:0] b,
		input logic                          keep_max
	);
		logic [pixel_width:0] diff;
		diff = {a[pixel_width-1], a} - {b[pixel_width-1], b};
		return (diff[pixel_width] == keep_max) ? b : a;
	endfunction

	assign want_max = (mode == mode_max_pool);

	always_ff @(posedge clk_5x)
	begin
		if (rst)
		begin
			beat_pipe  <= '0;
			first_pipe <= '0;
			last_pipe  <= '0;
		end
		else
		begin
			beat_pipe  <= {beat_pipe[0], beat.beat};
			first_pipe <= {first_pipe[0], beat.first};
			last_pipe  <= {last_pipe[pipe_latency-2:0], beat.last};
		end
	end

	always_ff @(posedge clk_5x)
	begin
		up_reg   <= pixel_upper;
		low_reg  <= pixel_lower;
		pair_reg <= pick(up_reg, low_reg, want_max);
		// the running extreme restarts from the first pair of a window
		if (beat_pipe[1])
		begin
			if (first_pipe[1])
				run_reg <= pair_reg;
			else
				run_reg <= pick(run_reg, pair_reg, want_max);
		end
		result <= acc_width'(run_reg);
	end

	assign last = last_pipe[pipe_latency-1];

endmodule

// File: source/cnn_ce_top.sv
`timescale 1ns/100ps

module cnn_ce_top
#(
	parameter int window_size_width = 4
)
(
	input  logic                                          clk_5x,
	input  logic                                          rst,
	input  logic                                          new_map,
	input  logic [window_size_width-1:0]                  window_size,
	input  logic [ce_ctrl_pkg::mode_width-1:0]            mode,
	input  logic signed [ce_params_pkg::acc_width-1:0]    cascade_datain,
	input  logic                                          cascade_datain_valid,
	input  logic                                          pixel_valid_upper,
	input  logic signed [ce_params_pkg::pixel_width-1:0]  pixel_datain_upper,
	input  logic                                          pixel_valid_lower,
	input  logic signed [ce_params_pkg::pixel_width-1:0]  pixel_datain_lower,
	input  logic                                          weight_valid_upper,
	input  logic signed [ce_params_pkg::weight_width-1:0] weight_datain_upper,
	input  logic                                          weight_valid_lower,
	input  logic signed [ce_params_pkg::weight_width-1:0] weight_datain_lower,
	output logic                                          dataout_valid,
	output logic [ce_params_pkg::acc_width-1:0]           dataout_p,
	output logic [ce_params_pkg::acc_width-1:0]           cascade_dataout,
	output logic                                          cascade_dataout_valid
);
	import ce_params_pkg::*;
	import ce_ctrl_pkg::*;

	// cascade_datain waits in the top until slice 0 reaches its P stage
	localparam int casc_depth = pipe_latency - 2;

	logic [mode_width-1:0]        mode_r;
	logic [window_size_width-1:0] window_size_r;
	logic                         pipe_clear;
	logic signed [acc_width-1:0]  casc_pipe [casc_depth];
	logic                         lower_ok;
	logic signed [pixel_width-1:0]  lower_pixel;
	logic signed [weight_width-1:0] lower_weight;
	logic signed [acc_width-1:0]  p0;
	logic signed [acc_width-1:0]  p1;
	logic                         conv_last;
	logic signed [acc_width-1:0]  pool_result;
	logic                         pool_last;

	ce_beat_if beat_bus ();

	// a new map drops any tag still in the pipes
	assign pipe_clear = rst | new_map;

	ce_config_regs #(.window_size_width(window_size_width)) config_regs_i
	(
		.clk_5x         (clk_5x),
		.rst            (rst),
		.new_map        (new_map),
		.mode_in        (mode),
		.window_size_in (window_size),
		.mode           (mode_r),
		.window_size    (window_size_r)
	);

	ce_window_ctrl #(.window_size_width(window_size_width)) window_ctrl_i
	(
		.clk_5x               (clk_5x),
		.rst                  (rst),
		.new_map              (new_map),
		.mode                 (mode_r),
		.window_size          (window_size_r),
		.pixel_valid_upper    (pixel_valid_upper),
		.pixel_valid_lower    (pixel_valid_lower),
		.weight_valid_upper   (weight_valid_upper),
		.cascade_datain_valid (cascade_datain_valid),
		.beat                 (beat_bus.ctrl)
	);

	always_ff @(posedge clk_5x)
	begin
		casc_pipe[0] <= beat_bus.cascade_take ? cascade_datain : '0;
		for (int i = 1; i < casc_depth; i++)
			casc_pipe[i] <= casc_pipe[i-1];
	end

	// an idle lower lane multiplies zero by zero
	assign lower_ok     = pixel_valid_lower & weight_valid_lower;
	assign lower_pixel  = lower_ok ? pixel_datain_lower : '0;
	assign lower_weight = lower_ok ? weight_datain_lower : '0;

	ce_macc_slice #(.use_feedback(1'b0)) slice_upper
	(
		.clk_5x (clk_5x),
		.rst    (pipe_clear),
		.pixel  (pixel_datain_upper),
		.weight (weight_datain_upper),
		.pcin   (casc_pipe[casc_depth-1]),
		.beat   (beat_bus.dp),
		.p      (p0),
		.last   ()
	);

	ce_macc_slice #(.use_feedback(1'b1)) slice_lower
	(
		.clk_5x (clk_5x),
		.rst    (pipe_clear),
		.pixel  (lower_pixel),
		.weight (lower_weight),
		.pcin   (p0),
		.beat   (beat_bus.dp),
		.p      (p1),
		.last   (conv_last)
	);

	ce_pool_unit pool_unit_i
	(
		.clk_5x      (clk_5x),
		.rst         (pipe_clear),
		.mode        (mode_r),
		.pixel_upper (pixel_datain_upper),
		.pixel_lower (pixel_datain_lower),
		.beat        (beat_bus.dp),
		.result      (pool_result),
		.last        (pool_last)
	);

	assign dataout_p             = (mode_r == mode_conv) ? p1 : pool_result;
	assign dataout_valid         = (mode_r == mode_conv) ? conv_last : pool_last;
	assign cascade_dataout       = p1;
	assign cascade_dataout_valid = dataout_valid;

endmodule

// File: dv/tb_cnn_ce.sv
`timescale 1ns/100ps

module tb_cnn_ce;
	import ce_params_pkg::*;
	import ce_ctrl_pkg::*;

	localparam int window_size_width = 4;

	logic                           clk_5x = 1'b0;
	logic                           rst;
	logic                           new_map;
	logic [window_size_width-1:0]   window_size;
	logic [mode_width-1:0]          mode;
	logic signed [acc_width-1:0]    cascade_datain;
	logic                           cascade_datain_valid;
	logic                           pixel_valid_upper;
	logic signed [pixel_width-1:0]  pixel_datain_upper;
	logic                           pixel_valid_lower;
	logic signed [pixel_width-1:0]  pixel_datain_lower;
	logic                           weight_valid_upper;
	logic signed [weight_width-1:0] weight_datain_upper;
	logic                           weight_valid_lower;
	logic signed [weight_width-1:0] weight_datain_lower;
	logic                           dataout_valid;
	logic [acc_width-1:0]           dataout_p;
	logic [acc_width-1:0]           cascade_dataout;
	logic                           cascade_dataout_valid;

	// windows still in flight, oldest first
	logic [acc_width-1:0] exp_value [$];
	int                   exp_due [$];
	string                exp_name [$];
	bit                   exp_conv [$];

	string       lines [$];
	string       test_name;
	int          cycle_count;
	int          cycle_limit;
	logic [15:0] lfsr_state;
	int          cur_mode;
	int          cur_ws;
	int          beat_index;
	longint      run_value;
	bit          have_result;

	cnn_ce_top #(.window_size_width(window_size_width)) cnn_ce_top_i
	(
		.clk_5x                (clk_5x),
		.rst                   (rst),
		.new_map               (new_map),
		.window_size           (window_size),
		.mode                  (mode),
		.cascade_datain        (cascade_datain),
		.cascade_datain_valid  (cascade_datain_valid),
		.pixel_valid_upper     (pixel_valid_upper),
		.pixel_datain_upper    (pixel_datain_upper),
		.pixel_valid_lower     (pixel_valid_lower),
		.pixel_datain_lower    (pixel_datain_lower),
		.weight_valid_upper    (weight_valid_upper),
		.weight_datain_upper   (weight_datain_upper),
		.weight_valid_lower    (weight_valid_lower),
		.weight_datain_lower   (weight_datain_lower),
		.dataout_valid         (dataout_valid),
		.dataout_p             (dataout_p),
		.cascade_dataout       (cascade_dataout),
		.cascade_dataout_valid (cascade_dataout_valid)
	);

	always #2 clk_5x = ~clk_5x;

	// taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic longint extreme(input longint a, input longint b, input bit want_max);
		if (want_max)
			return (a > b) ? a : b;
		return (a < b) ? a : b;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// two fresh bits give an idle gap of 0 to 3 cycles
	task automatic draw_gap(output int gap);
		lfsr_state = lfsr_step(lfsr_state);
		gap = int'(lfsr_state[0]);
		lfsr_state = lfsr_step(lfsr_state);
		gap = gap * 2 + int'(lfsr_state[0]);
	endtask

	task automatic drive_idle;
		new_map = 1'b0;
		cascade_datain = '0;
		cascade_datain_valid = 1'b0;
		pixel_valid_upper = 1'b0;
		pixel_datain_upper = '0;
		pixel_valid_lower = 1'b0;
		pixel_datain_lower = '0;
		weight_valid_upper = 1'b0;
		weight_datain_upper = '0;
		weight_valid_lower = 1'b0;
		weight_datain_lower = '0;
	endtask

	task automatic check_outputs;
		logic [acc_width-1:0] want;
		if (exp_due.size() > 0 && exp_due[0] == cycle_count)
		begin
			want = exp_value[0];
			assert (dataout_valid === 1'b1 && cascade_dataout_valid === 1'b1)
			else
				fail_run($sformatf("output valid missing for test %s at cycle %0d",
					exp_name[0], cycle_count));
			assert (dataout_p === want)
			else
				fail_run($sformatf("MISMATCH %s dataout_p expected %0d actual %0d",
					exp_name[0], $signed(want), $signed(dataout_p)));
			if (exp_conv[0])
			begin
				assert (cascade_dataout === want)
				else
					fail_run($sformatf("MISMATCH %s cascade_dataout expected %0d actual %0d",
						exp_name[0], $signed(want), $signed(cascade_dataout)));
			end
			void'(exp_value.pop_front());
			void'(exp_due.pop_front());
			void'(exp_name.pop_front());
			void'(exp_conv.pop_front());
		end
		else
		begin
			assert (dataout_valid === 1'b0 && cascade_dataout_valid === 1'b0)
			else
				fail_run($sformatf("an output valid rose at cycle %0d with no window due",
					cycle_count));
		end
	endtask

	// outputs are sampled on the falling edge, half a cycle after they change
	task automatic step;
		@(negedge clk_5x);
		cycle_count++;
		assert (cycle_count <= cycle_limit)
		else
			fail_run($sformatf("timeout after %0d cycles", cycle_limit));
		check_outputs();
	endtask

	task automatic drain;
		drive_idle();
		while (exp_due.size() > 0)
			step();
	endtask

	task automatic apply_config(input string line);
		int m;
		int w;
		int n;
		n = $sscanf(line, "C %s %d %d", test_name, m, w);
		assert (n == 3)
		else
			fail_run({"malformed config line in the stimulus file: ", line});
		drain();
		mode = mode_width'(m);
		window_size = window_size_width'(w);
		new_map = 1'b1;
		step();
		new_map = 1'b0;
		cur_mode = m;
		cur_ws = w;
		beat_index = 0;
		have_result = 1'b0;
	endtask

	task automatic run_beat(input string line);
		int pix_u, pix_l, wgt_u, wgt_l;
		int pv_u, pv_l, wv_u, wv_l;
		int casc_valid;
		longint casc;
		int gap;
		int n;
		bit is_beat;
		longint pair;
		n = $sscanf(line, "B %d %d %d %d %d %d %d %d %d %d", pix_u, pix_l, wgt_u, wgt_l,
			pv_u, pv_l, wv_u, wv_l, casc, casc_valid);
		assert (n == 10)
		else
			fail_run({"malformed beat line in the stimulus file: ", line});
		draw_gap(gap);
		drive_idle();
		repeat (gap)
			step();
		pixel_datain_upper = pixel_width'(pix_u);
		pixel_datain_lower = pixel_width'(pix_l);
		weight_datain_upper = weight_width'(wgt_u);
		weight_datain_lower = weight_width'(wgt_l);
		pixel_valid_upper = (pv_u != 0);
		pixel_valid_lower = (pv_l != 0);
		weight_valid_upper = (wv_u != 0);
		weight_valid_lower = (wv_l != 0);
		cascade_datain = acc_width'(casc);
		cascade_datain_valid = (casc_valid != 0);

		if (cur_mode == int'(mode_conv))
			is_beat = (pv_u != 0) && (wv_u != 0);
		else
			is_beat = (pv_u != 0) && (pv_l != 0);
		if (is_beat)
		begin
			if (cur_mode == int'(mode_conv))
			begin
				if (beat_index == 0)
					run_value = (casc_valid != 0) ? casc : 0;
				run_value += longint'(pix_u) * longint'(wgt_u);
				if (pv_l != 0 && wv_l != 0)
					run_value += longint'(pix_l) * longint'(wgt_l);
			end
			else
			begin
				pair = extreme(pix_u, pix_l, cur_mode == int'(mode_max_pool));
				if (beat_index == 0)
					run_value = pair;
				else
					run_value = extreme(run_value, pair, cur_mode == int'(mode_max_pool));
			end
			if (beat_index == cur_ws)
			begin
				exp_value.push_back(run_value[acc_width-1:0]);
				exp_due.push_back(cycle_count + pipe_latency);
				exp_name.push_back(test_name);
				exp_conv.push_back(cur_mode == int'(mode_conv));
				have_result = 1'b1;
				beat_index = 0;
			end
			else
				beat_index++;
		end
		step();
	endtask

	task automatic check_file_result(input string line);
		longint want;
		int n;
		n = $sscanf(line, "E %d", want);
		assert (n == 1 && have_result)
		else
			fail_run({"result line without a closed window in the stimulus file: ", line});
		assert (want == run_value)
		else
			fail_run($sformatf("MISMATCH %s stimulus file expects %0d, window rules give %0d",
				test_name, want, run_value));
		have_result = 1'b0;
	endtask

	initial
	begin
		int fd;
		string line;
		int beat_lines;
		int config_lines;
		byte kind;
		rst = 1'b1;
		mode = '0;
		window_size = '0;
		drive_idle();
		lfsr_state = 16'd36129;
		cycle_count = 0;
		cur_mode = int'(mode_conv);
		cur_ws = reset_window_size;
		beat_index = 0;
		run_value = 0;
		have_result = 1'b0;
		test_name = "after_reset";

		fd = $fopen("dv/cnn_ce_stimulus.txt", "r");
		assert (fd != 0)
		else
			fail_run("could not open dv/cnn_ce_stimulus.txt");
		beat_lines = 0;
		config_lines = 0;
		while ($fgets(line, fd) > 0)
		begin
			kind = line.getc(0);
			if (kind == "B")
				beat_lines++;
			else if (kind == "C")
				config_lines++;
			lines.push_back(line);
		end
		$fclose(fd);
		cycle_limit = (beat_lines + config_lines) * 5 + 50;

		repeat (2) @(posedge clk_5x);
		@(negedge clk_5x);
		rst = 1'b0;

		// nothing is driven yet, so no valid may rise
		repeat (8)
			step();

		foreach (lines[i])
		begin
			kind = lines[i].getc(0);
			case (kind)
				"C": apply_config(lines[i]);
				"B": run_beat(lines[i]);
				"E": check_file_result(lines[i]);
				default: ;
			endcase
		end
		drain();
		repeat (6)
			step();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: compile.f
source/ce_params_pkg.sv
source/ce_ctrl_pkg.sv
source/ce_beat_if.sv
source/ce_config_regs.sv
source/ce_window_ctrl.sv
source/ce_macc_slice.sv
source/ce_pool_unit.sv
source/cnn_ce_top.sv
dv/tb_cnn_ce.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cnn_ce -f compile.f -o sim_cnn_ce

# a run stopped by $fatal exits non-zero, so the log is searched instead
./obj_dir/sim_cnn_ce > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"

// File: dv/cnn_ce_stimulus.txt
# C name mode window_size | B pix_up pix_lo wgt_up wgt_lo pv_up pv_lo wv_up wv_lo casc casc_valid
# E result of the window that just closed | mode 0 conv, 1 max pool, 2 min pool
C conv_basic 0 3
B 3 -2 5 4 1 1 1 1 100 1
B -7 6 2 -3 1 1 1 1 0 0
B 10 1 -1 9 1 1 1 1 0 0
B 4 -5 8 -6 1 1 1 1 0 0
E 136
C conv_gaps 0 2
B 2 3 4 5 1 1 1 1 999 0
B -6 7 3 2 1 0 1 1 1000 1
B 1 1 1 1 1 1 1 1 0 0
E 7
B 20 -4 3 10 1 1 1 1 -50 1
B 5 9 -9 9 1 1 1 0 0 0
B -3 -3 -3 -3 1 1 1 1 0 0
E -57
C max_pool 1 2
B -5 -12 0 0 1 1 0 0 0 0
B -3 -20 0 0 1 1 0 0 0 0
B -8 -1 0 0 1 1 0 0 0 0
E -1
B 100 -300 0 0 1 1 0 0 0 0
B 250 7 0 0 1 1 0 0 0 0
B -1 249 0 0 1 1 0 0 0 0
E 250
C min_pool 2 0
B 5 -9 0 0 1 1 0 0 0 0
E -9
B -32768 32767 0 0 1 1 0 0 0 0
E -32768
C conv_again 0 1
B 1000 -1000 1000 1000 1 1 1 1 5 1
B 32767 -32768 32767 -32768 1 1 1 1 0 0
E 2147418118
